/* logic/fft_stage_pkg.sv */
package fft_stage_pkg;

  ////////////////////////////////////////////////////////////
  // Part widths
  ////////////////////////////////////////////////////////////

  // Q6.15 input part
  localparam int IN_W = 21;
  // One bit of butterfly growth, Q7.15
  localparam int SUM_W = IN_W + 1;
  // Q6.4 output part
  localparam int OUT_W = 10;

  ////////////////////////////////////////////////////////////
  // Stage defaults
  ////////////////////////////////////////////////////////////

  // Delay length and commutator block length
  localparam int unsigned STAGE_DEPTH = 16;
  // Fill latency of the earlier stages
  localparam int unsigned FILL_LATENCY = 17;
  // Fraction bits dropped going from Q7.15 to Q6.4
  localparam int FRAC_DROP = 11;

  ////////////////////////////////////////////////////////////
  // Word types, real part in the upper half
  ////////////////////////////////////////////////////////////

  typedef logic signed [IN_W-1:0] in_part_t;
  typedef logic [2*IN_W-1:0] cplx_in_t;

  typedef logic signed [SUM_W-1:0] sum_part_t;
  typedef logic [2*SUM_W-1:0] cplx_sum_t;

  typedef logic signed [OUT_W-1:0] out_part_t;
  typedef logic [2*OUT_W-1:0] cplx_out_t;

endpackage

/* logic/enable_delay.sv */
`timescale 1ns/100ps

module enable_delay #(
  parameter int unsigned LATENCY = fft_stage_pkg::FILL_LATENCY
) (
  input  logic clk,
  input  logic rst,
  input  logic level_in,
  output logic level_out
);

  // Wide enough to hold LATENCY itself
  localparam int CNT_W = $clog2(LATENCY + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(LATENCY);

  logic [CNT_W-1:0] count;

  // Consecutive high samples, sticks at LATENCY
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (!level_in) begin
      count <= '0;
    end else if (count != CNT_FULL) begin
      count <= count + 1'b1;
    end
  end

  // High from the LATENCY-th high sample on
  assign level_out = (count == CNT_FULL);

endmodule

/* logic/commutator_counter.sv */
`timescale 1ns/100ps

module commutator_counter #(
  parameter int unsigned DEPTH = fft_stage_pkg::STAGE_DEPTH
) (
  input  logic clk,
  input  logic rst,
  input  logic stage_en,
  output logic ctrl
);

  // Phase bit position, DEPTH is a power of two
  localparam int PHASE_BIT = $clog2(DEPTH);
  localparam int CNT_W = PHASE_BIT + 1;

  logic [CNT_W-1:0] count;

  ////////////////////////////////////////////////////////////
  // Enabled cycle count
  ////////////////////////////////////////////////////////////

  // Wraps freely, zero whenever the stage is idle
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (stage_en) begin
      count <= count + 1'b1;
    end else begin
      count <= '0;
    end
  end

  // Straight through as soon as the enable drops
  assign ctrl = stage_en & count[PHASE_BIT];

endmodule

/* logic/delay_line.sv */
`timescale 1ns/100ps

module delay_line #(
  parameter int unsigned DEPTH = fft_stage_pkg::STAGE_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  fft_stage_pkg::cplx_in_t  din,
  output fft_stage_pkg::cplx_in_t  dout
);

  fft_stage_pkg::cplx_in_t taps [DEPTH];

  // Shift chain, tap 0 is the newest word
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else begin
      taps[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // Oldest word leaves after DEPTH cycles
  assign dout = taps[DEPTH-1];

endmodule

/* logic/dc_butterfly.sv */
`timescale 1ns/100ps

module dc_butterfly #(
  parameter int unsigned DEPTH = fft_stage_pkg::STAGE_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ctrl,
  input  fft_stage_pkg::cplx_in_t   in_up,
  input  fft_stage_pkg::cplx_in_t   in_down,
  output fft_stage_pkg::cplx_sum_t  sum,
  output fft_stage_pkg::cplx_sum_t  diff
);

  localparam int IN_W = fft_stage_pkg::IN_W;

  fft_stage_pkg::cplx_in_t down_dly;
  fft_stage_pkg::cplx_in_t upper;
  fft_stage_pkg::cplx_in_t lower;
  fft_stage_pkg::cplx_in_t upper_dly;

  fft_stage_pkg::in_part_t up_re;
  fft_stage_pkg::in_part_t up_im;
  fft_stage_pkg::in_part_t lo_re;
  fft_stage_pkg::in_part_t lo_im;

  fft_stage_pkg::sum_part_t up_re_x;
  fft_stage_pkg::sum_part_t up_im_x;
  fft_stage_pkg::sum_part_t lo_re_x;
  fft_stage_pkg::sum_part_t lo_im_x;

  fft_stage_pkg::sum_part_t sum_re;
  fft_stage_pkg::sum_part_t sum_im;
  fft_stage_pkg::sum_part_t diff_re;
  fft_stage_pkg::sum_part_t diff_im;

  ////////////////////////////////////////////////////////////
  // Delay, commutate, delay
  ////////////////////////////////////////////////////////////

  delay_line #(.DEPTH(DEPTH)) down_delay_i (
    .clk  (clk),
    .rst  (rst),
    .din  (in_down),
    .dout (down_dly)
  );

  // Swap branches in the odd blocks
  assign upper = ctrl ? down_dly : in_up;
  assign lower = ctrl ? in_up : down_dly;

  delay_line #(.DEPTH(DEPTH)) upper_delay_i (
    .clk  (clk),
    .rst  (rst),
    .din  (upper),
    .dout (upper_dly)
  );

  ////////////////////////////////////////////////////////////
  // Radix-2 butterfly
  ////////////////////////////////////////////////////////////

  assign up_re = upper_dly[2*IN_W-1:IN_W];
  assign up_im = upper_dly[IN_W-1:0];
  assign lo_re = lower[2*IN_W-1:IN_W];
  assign lo_im = lower[IN_W-1:0];

  // Sign extension for one bit of growth
  assign up_re_x = {up_re[IN_W-1], up_re};
  assign up_im_x = {up_im[IN_W-1], up_im};
  assign lo_re_x = {lo_re[IN_W-1], lo_re};
  assign lo_im_x = {lo_im[IN_W-1], lo_im};

  always_ff @(posedge clk) begin
    if (rst) begin
      sum_re  <= '0;
      sum_im  <= '0;
      diff_re <= '0;
      diff_im <= '0;
    end else begin
      sum_re  <= up_re_x + lo_re_x;
      sum_im  <= up_im_x + lo_im_x;
      diff_re <= up_re_x - lo_re_x;
      diff_im <= up_im_x - lo_im_x;
    end
  end

  assign sum  = {sum_re, sum_im};
  assign diff = {diff_re, diff_im};

endmodule

/* logic/requant_sat.sv */
`timescale 1ns/100ps

module requant_sat (
  input  fft_stage_pkg::cplx_sum_t  sat_in,
  output fft_stage_pkg::cplx_out_t  sat_out
);

  localparam int SUM_W = fft_stage_pkg::SUM_W;
  localparam int OUT_W = fft_stage_pkg::OUT_W;

  // Q6.4 limits, widened to the sum width for the compare
  localparam fft_stage_pkg::sum_part_t OUT_MAX = (2 ** (OUT_W - 1)) - 1;
  localparam fft_stage_pkg::sum_part_t OUT_MIN = -(2 ** (OUT_W - 1));

  fft_stage_pkg::sum_part_t in_re;
  fft_stage_pkg::sum_part_t in_im;

  // Floor by the dropped fraction bits, then clamp
  function automatic fft_stage_pkg::out_part_t sat_part(
    input fft_stage_pkg::sum_part_t part
  );
    fft_stage_pkg::sum_part_t shifted;
    fft_stage_pkg::out_part_t result;
    shifted = part >>> fft_stage_pkg::FRAC_DROP;
    if (shifted > OUT_MAX) begin
      result = OUT_MAX[OUT_W-1:0];
    end else if (shifted < OUT_MIN) begin
      result = OUT_MIN[OUT_W-1:0];
    end else begin
      result = shifted[OUT_W-1:0];
    end
    return result;
  endfunction

  assign in_re = sat_in[2*SUM_W-1:SUM_W];
  assign in_im = sat_in[SUM_W-1:0];

  assign sat_out = {sat_part(in_re), sat_part(in_im)};

endmodule

/* logic/fft_last_stage.sv */
`timescale 1ns/100ps

module fft_last_stage #(
  parameter int unsigned DEPTH = fft_stage_pkg::STAGE_DEPTH,
  parameter int unsigned FILL  = fft_stage_pkg::FILL_LATENCY
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_enable,
  input  fft_stage_pkg::cplx_in_t   in0_up,
  input  fft_stage_pkg::cplx_in_t   in0_down,
  input  fft_stage_pkg::cplx_in_t   in1_up,
  input  fft_stage_pkg::cplx_in_t   in1_down,
  output fft_stage_pkg::cplx_out_t  out0_up,
  output fft_stage_pkg::cplx_out_t  out0_down,
  output fft_stage_pkg::cplx_out_t  out1_up,
  output fft_stage_pkg::cplx_out_t  out1_down
);

  logic stage_en;
  logic ctrl;

  fft_stage_pkg::cplx_sum_t sum0;
  fft_stage_pkg::cplx_sum_t diff0;
  fft_stage_pkg::cplx_sum_t sum1;
  fft_stage_pkg::cplx_sum_t diff1;

  fft_stage_pkg::cplx_out_t q0_up;
  fft_stage_pkg::cplx_out_t q0_down;
  fft_stage_pkg::cplx_out_t q1_up;
  fft_stage_pkg::cplx_out_t q1_down;

  ////////////////////////////////////////////////////////////
  // Enable and commutator control
  ////////////////////////////////////////////////////////////

  // Stage starts once the earlier stages have filled
  enable_delay #(.LATENCY(FILL)) enable_delay_i (
    .clk       (clk),
    .rst       (rst),
    .level_in  (in_enable),
    .level_out (stage_en)
  );

  commutator_counter #(.DEPTH(DEPTH)) commutator_counter_i (
    .clk      (clk),
    .rst      (rst),
    .stage_en (stage_en),
    .ctrl     (ctrl)
  );

  ////////////////////////////////////////////////////////////
  // Butterflies, one per lane, shared phase
  ////////////////////////////////////////////////////////////

  dc_butterfly #(.DEPTH(DEPTH)) lane0_bf_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .in_up   (in0_up),
    .in_down (in0_down),
    .sum     (sum0),
    .diff    (diff0)
  );

  dc_butterfly #(.DEPTH(DEPTH)) lane1_bf_i (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .in_up   (in1_up),
    .in_down (in1_down),
    .sum     (sum1),
    .diff    (diff1)
  );

  ////////////////////////////////////////////////////////////
  // Requantize Q7.15 to Q6.4
  ////////////////////////////////////////////////////////////

  requant_sat sat0_up_i (
    .sat_in  (sum0),
    .sat_out (q0_up)
  );

  requant_sat sat0_down_i (
    .sat_in  (diff0),
    .sat_out (q0_down)
  );

  requant_sat sat1_up_i (
    .sat_in  (sum1),
    .sat_out (q1_up)
  );

  requant_sat sat1_down_i (
    .sat_in  (diff1),
    .sat_out (q1_down)
  );

  // Output register
  always_ff @(posedge clk) begin
    if (rst) begin
      out0_up   <= '0;
      out0_down <= '0;
      out1_up   <= '0;
      out1_down <= '0;
    end else begin
      out0_up   <= q0_up;
      out0_down <= q0_down;
      out1_up   <= q1_up;
      out1_down <= q1_down;
    end
  end

endmodule

/* tests/fft_ref_model.svh */
`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state;

function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// Signed value built from nbits fresh bits
function automatic int rand_part(input int nbits);
  int v;
  v = 0;
  for (int b = 0; b < nbits; b++) begin
    v = (v << 1) | int'(lfsr_bit());
  end
  if (v >= (1 << (nbits - 1))) begin
    v = v - (1 << nbits);
  end
  return v;
endfunction

////////////////////////////////////////////////////////////
// Model state, indexed [lane][0 up or sum, 1 down or diff]
////////////////////////////////////////////////////////////

int run_len;
int enabled_k;
int buf_ptr;
int clamp_count;
fft_stage_pkg::cplx_in_t down_buf [2][DEPTH];
fft_stage_pkg::cplx_in_t upper_buf [2][DEPTH];
int bf_re [2][2];
int bf_im [2][2];
int exp_re [2][2];
int exp_im [2][2];

// Floor by the dropped fraction weight, then clamp to Q6.4
function automatic int requant(input int v);
  int q;
  if (v >= 0) begin
    q = v / (1 << FRAC_DROP);
  end else begin
    q = -((-v + (1 << FRAC_DROP) - 1) / (1 << FRAC_DROP));
  end
  if (q > OUT_MAX || q < OUT_MIN) begin
    clamp_count++;
    q = (q > OUT_MAX) ? OUT_MAX : OUT_MIN;
  end
  return q;
endfunction

// Odd blocks of enabled cycles swap the branches
function automatic logic model_ctrl();
  return (run_len >= FILL) && ((enabled_k / DEPTH) % 2 == 1);
endfunction

task automatic advance_model(input logic rst_s, input logic en_s,
                             input fft_stage_pkg::cplx_in_t up0,
                             input fft_stage_pkg::cplx_in_t down0,
                             input fft_stage_pkg::cplx_in_t up1,
                             input fft_stage_pkg::cplx_in_t down1);
  fft_stage_pkg::cplx_in_t ups [2];
  fft_stage_pkg::cplx_in_t downs [2];
  fft_stage_pkg::cplx_in_t old_down;
  fft_stage_pkg::cplx_in_t old_upper;
  fft_stage_pkg::cplx_in_t upper;
  fft_stage_pkg::cplx_in_t lower;
  logic ctrl_now;
  int ur;
  int ui;
  int lr;
  int li;
  ups[0] = up0;
  ups[1] = up1;
  downs[0] = down0;
  downs[1] = down1;
  if (rst_s) begin
    down_buf = '{default: '0};
    upper_buf = '{default: '0};
    bf_re = '{default: 0};
    bf_im = '{default: 0};
    exp_re = '{default: 0};
    exp_im = '{default: 0};
    run_len = 0;
    enabled_k = 0;
    buf_ptr = 0;
  end else begin
    ctrl_now = model_ctrl();
    for (int l = 0; l < 2; l++) begin
      // Output register sees the butterfly register before this edge
      for (int j = 0; j < 2; j++) begin
        exp_re[l][j] = requant(bf_re[l][j]);
        exp_im[l][j] = requant(bf_im[l][j]);
      end
      // Circular buffers, slot at buf_ptr was written DEPTH edges ago
      old_down = down_buf[l][buf_ptr];
      old_upper = upper_buf[l][buf_ptr];
      upper = ctrl_now ? old_down : ups[l];
      lower = ctrl_now ? ups[l] : old_down;
      ur = $signed(old_upper[2*IN_W-1:IN_W]);
      ui = $signed(old_upper[IN_W-1:0]);
      lr = $signed(lower[2*IN_W-1:IN_W]);
      li = $signed(lower[IN_W-1:0]);
      bf_re[l][0] = ur + lr;
      bf_im[l][0] = ui + li;
      bf_re[l][1] = ur - lr;
      bf_im[l][1] = ui - li;
      down_buf[l][buf_ptr] = downs[l];
      upper_buf[l][buf_ptr] = upper;
    end
    buf_ptr = (buf_ptr + 1) % DEPTH;
    enabled_k = (run_len >= FILL) ? enabled_k + 1 : 0;
    if (!en_s) begin
      run_len = 0;
    end else if (run_len < FILL) begin
      run_len++;
    end
  end
endtask

`endif

/* tests/fft_last_stage_tb.sv */
`timescale 1ns/100ps

module fft_last_stage_tb;

  localparam int DEPTH = fft_stage_pkg::STAGE_DEPTH;
  localparam int FILL = fft_stage_pkg::FILL_LATENCY;
  localparam int IN_W = fft_stage_pkg::IN_W;
  localparam int OUT_W = fft_stage_pkg::OUT_W;
  localparam int FRAC_DROP = fft_stage_pkg::FRAC_DROP;
  localparam int OUT_MAX = (1 << (OUT_W - 1)) - 1;
  localparam int OUT_MIN = -(1 << (OUT_W - 1));
  localparam int CLK_NS = 8;
  localparam int RESET_CYCLES = 10;
  localparam int LOW_CYCLES = 5;

  // Cycle budget of each test
  localparam int T1 = DEPTH;
  localparam int T2 = FILL + 6 * DEPTH;
  localparam int T3 = 8 * DEPTH;
  localparam int T4 = 4 * DEPTH;
  localparam int T5 = 3 * DEPTH + LOW_CYCLES + FILL + 5 * DEPTH + 4;
  localparam int RUN_CYCLES = RESET_CYCLES + T1 + T2 + T3 + T4 + T5;

  logic clk;
  logic rst;
  logic in_enable;
  fft_stage_pkg::cplx_in_t in0_up;
  fft_stage_pkg::cplx_in_t in0_down;
  fft_stage_pkg::cplx_in_t in1_up;
  fft_stage_pkg::cplx_in_t in1_down;
  fft_stage_pkg::cplx_out_t out0_up;
  fft_stage_pkg::cplx_out_t out0_down;
  fft_stage_pkg::cplx_out_t out1_up;
  fft_stage_pkg::cplx_out_t out1_down;

  bit checking;
  int test_id;
  int test_cycle;
  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;
  int tests_done;
  int impulse_hits;
  bit saw_max;
  bit saw_min;

  `include "fft_ref_model.svh"

  fft_last_stage #(.DEPTH(DEPTH), .FILL(FILL)) fft_last_stage_i (
    .clk       (clk),
    .rst       (rst),
    .in_enable (in_enable),
    .in0_up    (in0_up),
    .in0_down  (in0_down),
    .in1_up    (in1_up),
    .in1_down  (in1_down),
    .out0_up   (out0_up),
    .out0_down (out0_down),
    .out1_up   (out1_up),
    .out1_down (out1_down)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(CLK_NS * (RUN_CYCLES + 100));
    $display("Watchdog expired, run did not finish within %0d cycles", RUN_CYCLES + 100);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic fft_stage_pkg::cplx_in_t make_word(input int re, input int im);
    return {re[IN_W-1:0], im[IN_W-1:0]};
  endfunction

  function automatic fft_stage_pkg::cplx_in_t rand_word(input int nbits);
    int re;
    int im;
    re = rand_part(nbits);
    im = rand_part(nbits);
    return make_word(re, im);
  endfunction

  // Near full scale with one random sign for both parts
  function automatic fft_stage_pkg::cplx_in_t big_word();
    int mag_re;
    int mag_im;
    logic neg;
    neg = lfsr_bit();
    mag_re = (1 << (IN_W - 1)) - 128 + rand_part(8);
    mag_im = (1 << (IN_W - 1)) - 128 + rand_part(8);
    return neg ? make_word(-mag_re, -mag_im) : make_word(mag_re, mag_im);
  endfunction

  task automatic drive_cycle(input logic en, input fft_stage_pkg::cplx_in_t u0,
                             input fft_stage_pkg::cplx_in_t d0,
                             input fft_stage_pkg::cplx_in_t u1,
                             input fft_stage_pkg::cplx_in_t d1);
    @(posedge clk);
    in_enable <= en;
    in0_up <= u0;
    in0_down <= d0;
    in1_up <= u1;
    in1_down <= d1;
    test_cycle++;
  endtask

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic start_test(input int id);
    test_id = id;
    test_cycle = 0;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    tests_done++;
  endtask

  task automatic compare_word(input string name, input fft_stage_pkg::cplx_out_t got,
                              input int want_re, input int want_im);
    int got_re;
    int got_im;
    got_re = $signed(got[2*OUT_W-1:OUT_W]);
    got_im = $signed(got[OUT_W-1:0]);
    assert (got_re == want_re) else begin
      $display("ERR %0t %s.re got %0d expected %0d", $time, name, got_re, want_re);
      note_error();
    end
    assert (got_im == want_im) else begin
      $display("ERR %0t %s.im got %0d expected %0d", $time, name, got_im, want_im);
      note_error();
    end
    saw_max |= (got_re == OUT_MAX) || (got_im == OUT_MAX);
    saw_min |= (got_re == OUT_MIN) || (got_im == OUT_MIN);
  endtask

  ////////////////////////////////////////////////////////////
  // Model update and compare
  ////////////////////////////////////////////////////////////

  // Sees the inputs as the DUT samples them
  always @(posedge clk) begin
    advance_model(rst, in_enable, in0_up, in0_down, in1_up, in1_down);
  end

  // Outputs are settled half a cycle after the edge
  always @(negedge clk) begin
    if (checking) begin
      compare_word("out0_up", out0_up, exp_re[0][0], exp_im[0][0]);
      compare_word("out0_down", out0_down, exp_re[0][1], exp_im[0][1]);
      compare_word("out1_up", out1_up, exp_re[1][0], exp_im[1][0]);
      compare_word("out1_down", out1_down, exp_re[1][1], exp_im[1][1]);
      test_checks++;
      total_checks++;
      assert (fft_last_stage_i.ctrl == model_ctrl()) else begin
        $display("ERR %0t ctrl got %0b expected %0b", $time,
                 fft_last_stage_i.ctrl, model_ctrl());
        note_error();
      end
      if (test_id == 1) begin
        assert ({out0_up, out0_down, out1_up, out1_down} == '0) else begin
          $display("ERR %0t outputs got %h expected 0", $time,
                   {out0_up, out0_down, out1_up, out1_down});
          note_error();
        end
      end
      // Earlier data has drained by then
      if (test_id == 2 && test_cycle >= 2 * DEPTH + 4) begin
        impulse_hits += (out0_up != '0 || out0_down != '0) ? 1 : 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int hi_run;
    fft_stage_pkg::cplx_in_t d0;
    lfsr_state = 32'he638_4e1b;
    rst = 1'b1;
    in_enable = 1'b0;
    in0_up = '0;
    in0_down = '0;
    in1_up = '0;
    in1_down = '0;
    checking = 1'b0;
    tests_done = 0;
    total_checks = 0;
    total_errors = 0;
    start_test(1);
    @(posedge clk);
    checking = 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;

    // Data enters empty delay lines so nothing may come out yet
    for (int c = 0; c < T1; c++) begin
      drive_cycle(1'b0, rand_word(20), rand_word(20), rand_word(20), rand_word(20));
    end
    end_test("reset");

    // Enable fill with impulses on lane 0 down
    start_test(2);
    impulse_hits = 0;
    for (int c = 0; c < T2; c++) begin
      d0 = '0;
      if (c % 8 == 3 && c < FILL + 4 * DEPTH) begin
        d0 = make_word((c / 8 + 1) << FRAC_DROP, -((c / 8 + 1) << FRAC_DROP));
      end
      drive_cycle(1'b1, '0, d0, '0, '0);
    end
    assert (impulse_hits > 0) else begin
      $display("No impulse reached the lane 0 outputs after the enable fill");
      note_error();
    end
    end_test("enable_fill");

    start_test(3);
    for (int c = 0; c < T3; c++) begin
      drive_cycle(1'b1, rand_word(19), rand_word(19), rand_word(19), rand_word(19));
    end
    end_test("random");

    start_test(4);
    saw_max = 1'b0;
    saw_min = 1'b0;
    clamp_count = 0;
    for (int c = 0; c < T4; c++) begin
      drive_cycle(1'b1, big_word(), big_word(), big_word(), big_word());
    end
    assert (saw_max && saw_min) else begin
      $display("Outputs never reached both saturation limits");
      note_error();
    end
    $display("saturation: %0d clamped parts", clamp_count);
    end_test("saturation");

    // Drop the enable in the middle of a swapped block
    start_test(5);
    hi_run = 0;
    for (int c = 0; c < 3 * DEPTH && hi_run < DEPTH / 2; c++) begin
      drive_cycle(1'b1, rand_word(19), rand_word(19), rand_word(19), rand_word(19));
      @(negedge clk);
      hi_run = model_ctrl() ? hi_run + 1 : 0;
    end
    for (int c = 0; c < LOW_CYCLES; c++) begin
      drive_cycle(1'b0, rand_word(19), rand_word(19), rand_word(19), rand_word(19));
      @(negedge clk);
      if (c == 1) begin
        assert (fft_last_stage_i.ctrl == 1'b0) else begin
          $display("ERR %0t ctrl got %0b expected 0", $time, fft_last_stage_i.ctrl);
          note_error();
        end
      end
    end
    for (int c = 0; c < FILL + 3 * DEPTH; c++) begin
      drive_cycle(1'b1, rand_word(19), rand_word(19), rand_word(19), rand_word(19));
    end
    for (int c = 0; c < 2 * DEPTH + 4; c++) begin
      drive_cycle(1'b1, '0, '0, '0, '0);
    end
    end_test("enable_drop");

    @(posedge clk);
    checking = 1'b0;
    $display("summary: %0d tests, %0d checks, %0d errors",
             tests_done, total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+tests
logic/fft_stage_pkg.sv
logic/enable_delay.sv
logic/commutator_counter.sv
logic/delay_line.sv
logic/dc_butterfly.sv
logic/requant_sat.sv
logic/fft_last_stage.sv
tests/fft_last_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the FFT last stage testbench with Verilator

LOG=sim.log
OBJ=obj_dir

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module fft_last_stage_tb --Mdir "$OBJ" -o fft_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$OBJ/fft_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0
